// ==== list.f ====
hw/udp_csum_pkg.sv
hw/udp_csum_fsm.sv
hw/udp_len_counter.sv
hw/udp_csum_accum.sv
hw/hdr_fifo.sv
hw/payload_fifo.sv
hw/udp_csum_gen.sv
dv/udp_csum_gen_tb.sv

// ==== dv/udp_csum_gen_tb.sv ====
// testbench for the udp checksum generator with frame table, checksum model and output checks
`timescale 1ns/100ps

module udp_csum_gen_tb import udp_csum_pkg::*; ();

    localparam int pdepth     = 4;
    localparam int hdepth     = 4;
    localparam int n_frames   = 14;
    localparam int wait_limit = 500;

    typedef struct packed {
        logic [ip_w-1:0]   src_ip;
        logic [ip_w-1:0]   dst_ip;
        logic [port_w-1:0] src_port;
        logic [port_w-1:0] dst_port;
        logic [7:0]        nbytes;
        logic              stall;
    } frame_t;

    typedef struct packed {
        logic [ip_w-1:0]   src_ip;
        logic [ip_w-1:0]   dst_ip;
        logic [port_w-1:0] src_port;
        logic [port_w-1:0] dst_port;
        logic [len_w-1:0]  length;
        logic [csum_w-1:0] csum;
    } hdr_t;

    typedef struct packed {
        logic              last;
        logic [keep_w-1:0] keep;
        logic [data_w-1:0] data;
    } beat_t;

    logic clk, rst;
    logic s_hdr_valid, s_hdr_ready, s_tvalid, s_tready, s_tlast;
    logic m_hdr_valid, m_hdr_ready, m_tvalid, m_tready, m_tlast, busy;
    logic [ip_w-1:0] s_src_ip, s_dst_ip, m_src_ip, m_dst_ip;
    logic [port_w-1:0] s_src_port, s_dst_port, m_src_port, m_dst_port;
    logic [data_w-1:0] s_tdata, m_tdata;
    logic [keep_w-1:0] s_tkeep, m_tkeep;
    logic [len_w-1:0] m_udp_length;
    logic [csum_w-1:0] m_udp_checksum;

    frame_t     frames [n_frames];
    logic [7:0] pay_bytes [64];
    hdr_t       exp_hdr_q [$];
    beat_t      exp_beat_q [$];
    integer     seed;
    int         hdr_sent  = 0;
    int         hdr_taken = 0;
    int         stall_low = 0;
    int         out_cyc   = 0;
    logic       hold_hdr  = 1'b0;
    logic       throttle  = 1'b0;
    logic       full_seen = 1'b0;

    udp_csum_gen #(.PAYLOAD_DEPTH(pdepth), .HDR_DEPTH(hdepth)) dut0 (
        .clk(clk), .rst(rst), .s_hdr_valid(s_hdr_valid), .s_hdr_ready(s_hdr_ready),
        .s_src_ip(s_src_ip), .s_dst_ip(s_dst_ip), .s_src_port(s_src_port),
        .s_dst_port(s_dst_port), .s_tdata(s_tdata), .s_tkeep(s_tkeep), .s_tvalid(s_tvalid),
        .s_tready(s_tready), .s_tlast(s_tlast), .m_hdr_valid(m_hdr_valid),
        .m_hdr_ready(m_hdr_ready), .m_src_ip(m_src_ip), .m_dst_ip(m_dst_ip),
        .m_src_port(m_src_port), .m_dst_port(m_dst_port), .m_udp_length(m_udp_length),
        .m_udp_checksum(m_udp_checksum), .m_tdata(m_tdata), .m_tkeep(m_tkeep),
        .m_tvalid(m_tvalid), .m_tready(m_tready), .m_tlast(m_tlast), .busy(busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string msg);
        stop_run($sformatf("Mismatch at %0t ns: %s", $time, msg));
    endtask

    task automatic report_timeout(input string what);
        stop_run($sformatf("timeout at %0t ns: %s did not happen", $time, what));
    endtask

    // src ip, dst ip, src port, dst port, payload bytes, output stall
    task automatic load_frames();
        frames[0]  = '{32'h0a000001, 32'h0a000002, 16'd1234,  16'd53,    8'd1,  1'b0};
        frames[1]  = '{32'hc0a80101, 32'hc0a801fe, 16'd5000,  16'd6000,  8'd7,  1'b0};
        frames[2]  = '{32'hac100001, 32'hac10ffff, 16'hffff,  16'h0001,  8'd8,  1'b0};
        frames[3]  = '{32'h7f000001, 32'h08080808, 16'd40000, 16'd80,    8'd13, 1'b0};
        frames[4]  = '{32'h00000000, 32'h00000000, 16'd9,     16'd9,     8'd64, 1'b0};
        frames[5]  = '{32'hffffffff, 32'h00000000, 16'd0,     16'hffff,  8'd20, 1'b0};
        // short frames with the header output held back
        frames[6]  = '{32'h0a0a0a01, 32'h0a0a0a02, 16'd100,   16'd200,   8'd3,  1'b1};
        frames[7]  = '{32'h0a0a0a03, 32'h0a0a0a04, 16'd101,   16'd201,   8'd5,  1'b1};
        frames[8]  = '{32'h0a0a0a05, 32'h0a0a0a06, 16'd102,   16'd202,   8'd2,  1'b1};
        frames[9]  = '{32'h0a0a0a07, 32'h0a0a0a08, 16'd103,   16'd203,   8'd9,  1'b1};
        frames[10] = '{32'h0a0a0a09, 32'h0a0a0a0a, 16'd104,   16'd204,   8'd4,  1'b1};
        frames[11] = '{32'h0a0a0a0b, 32'h0a0a0a0c, 16'd105,   16'd205,   8'd6,  1'b1};
        frames[12] = '{32'h00000000, 32'hc0a80001, 16'd4789,  16'd4789,  8'd64, 1'b1};
        frames[13] = '{32'h01020304, 32'h05060708, 16'd2152,  16'd2152,  8'd16, 1'b0};
    endtask

    // pseudo-header, udp header and payload as 16-bit words, folded and inverted
    function automatic logic [csum_w-1:0] expected_csum(input frame_t f, input int n);
        logic [31:0] acc;
        logic [15:0] len;
        logic [15:0] word;
        len = 16'(n + 8);
        acc = 32'(f.src_ip[31:16]) + 32'(f.src_ip[15:0]) + 32'(f.dst_ip[31:16]) +
              32'(f.dst_ip[15:0]);
        acc = acc + 32'h0011 + 32'(len) + 32'(len) + 32'(f.src_port) + 32'(f.dst_port);
        for (int i = 0; i < n; i += 2) begin
            word = {pay_bytes[i], (i + 1 < n) ? pay_bytes[i + 1] : 8'h00};
            acc  = acc + 32'(word);
        end
        while (acc[31:16] != 16'h0000) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        return ~acc[15:0];
    endfunction

    // holds while the header FIFO is full, then lets the consumer drain it
    task automatic check_full_hold();
        repeat (20) begin
            @(negedge clk);
            #1;
            assert (!s_hdr_ready)
                else report_mismatch("s_hdr_ready high while the header FIFO is full");
        end
        assert (!busy) else report_mismatch("busy still high while waiting on a full FIFO");
        assert (m_hdr_valid) else report_mismatch("m_hdr_valid low with headers queued");
        full_seen = 1'b1;
        @(posedge clk);
        hold_hdr = 1'b0;
    endtask

    task automatic send_frame(input int idx, input logic prev_stall);
        frame_t            f;
        beat_t             beats [8];
        hdr_t              exp;
        logic [data_w-1:0] bdata;
        logic [31:0]       rnd;
        int                n;
        int                nbeats;
        int                k;
        int                waited;
        f      = frames[idx];
        n      = int'(f.nbytes);
        nbeats = (n + 7) / 8;
        for (int i = 0; i < n; i++) begin
            rnd          = $random(seed);
            pay_bytes[i] = rnd[7:0];
        end
        exp = '{f.src_ip, f.dst_ip, f.src_port, f.dst_port, 16'(n + 8), expected_csum(f, n)};
        exp_hdr_q.push_back(exp);
        for (int b = 0; b < nbeats; b++) begin
            k     = (n - 8 * b > 8) ? 8 : n - 8 * b;
            bdata = '0;
            for (int j = 0; j < k; j++) begin
                bdata[j*8 +: 8] = pay_bytes[8 * b + j];
            end
            beats[b] = '{(b == nbeats - 1), 8'((9'd1 << k) - 9'd1), bdata};
            exp_beat_q.push_back(beats[b]);
        end
        @(posedge clk);
        throttle = f.stall;
        if (!f.stall) begin
            hold_hdr = 1'b0;
        end else if (!prev_stall) begin
            hold_hdr = 1'b1;
        end
        if (hold_hdr && (hdr_sent - hdr_taken > hdepth)) begin
            check_full_hold();
        end
        @(negedge clk);
        s_src_ip    = f.src_ip;
        s_dst_ip    = f.dst_ip;
        s_src_port  = f.src_port;
        s_dst_port  = f.dst_port;
        s_hdr_valid = 1'b1;
        waited      = 0;
        #1;
        while (!s_hdr_ready) begin
            waited++;
            if (waited > wait_limit) report_timeout("header accept on s_hdr_ready");
            @(negedge clk);
            #1;
        end
        assert (!busy) else report_mismatch("busy high when a header is accepted");
        @(posedge clk);
        hdr_sent++;
        @(negedge clk);
        s_hdr_valid = 1'b0;
        assert (busy) else report_mismatch("busy low right after a header was accepted");
        for (int b = 0; b < nbeats; b++) begin
            s_tdata  = beats[b].data;
            s_tkeep  = beats[b].keep;
            s_tlast  = beats[b].last;
            s_tvalid = 1'b1;
            waited   = 0;
            #1;
            while (!s_tready) begin
                // mid-frame only a full payload FIFO drops s_tready
                if (b > 0) stall_low++;
                waited++;
                if (waited > wait_limit) report_timeout("payload beat accept on s_tready");
                @(negedge clk);
                #1;
            end
            @(negedge clk);
        end
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
        s_tkeep  = '0;
        s_tdata  = '0;
    endtask

    task automatic check_header();
        hdr_t exp;
        assert (exp_hdr_q.size() > 0) else stop_run("a header came out that was never sent");
        exp = exp_hdr_q.pop_front();
        assert (m_udp_length == exp.length)
            else report_mismatch($sformatf("udp length %0d, expected %0d",
                                           m_udp_length, exp.length));
        assert (m_udp_checksum == exp.csum)
            else report_mismatch($sformatf("udp checksum %h, expected %h",
                                           m_udp_checksum, exp.csum));
        assert ({m_src_ip, m_dst_ip, m_src_port, m_dst_port} ==
                {exp.src_ip, exp.dst_ip, exp.src_port, exp.dst_port})
            else report_mismatch($sformatf("header fields %h %h %h %h, expected %h %h %h %h",
                                           m_src_ip, m_dst_ip, m_src_port, m_dst_port,
                                           exp.src_ip, exp.dst_ip, exp.src_port,
                                           exp.dst_port));
    endtask

    task automatic check_beat();
        beat_t exp;
        assert (exp_beat_q.size() > 0)
            else stop_run("a payload beat came out that was never sent");
        exp = exp_beat_q.pop_front();
        assert ({m_tlast, m_tkeep, m_tdata} == exp)
            else report_mismatch($sformatf("beat last %b keep %h data %h, expected %b %h %h",
                                           m_tlast, m_tkeep, m_tdata,
                                           exp.last, exp.keep, exp.data));
    endtask

    // output consumer with readys changing on the falling edge
    initial begin
        m_hdr_ready = 1'b0;
        m_tready    = 1'b0;
        forever begin
            @(negedge clk);
            out_cyc++;
            m_hdr_ready = !hold_hdr;
            m_tready    = !throttle || (out_cyc % 4 == 0);
            #1;
            if (m_hdr_valid && m_hdr_ready) begin
                check_header();
                hdr_taken++;
            end
            if (m_tvalid && m_tready) begin
                check_beat();
            end
        end
    end

    initial begin
        int waited;
        seed        = 32'hf6c3ec24;
        rst         = 1'b1;
        s_hdr_valid = 1'b0;
        s_src_ip    = '0;
        s_dst_ip    = '0;
        s_src_port  = '0;
        s_dst_port  = '0;
        s_tdata     = '0;
        s_tkeep     = '0;
        s_tvalid    = 1'b0;
        s_tlast     = 1'b0;
        load_frames();
        repeat (5) @(posedge clk);
        @(negedge clk);
        assert (!s_hdr_ready && !s_tready && !m_hdr_valid && !m_tvalid && !busy)
            else report_mismatch("outputs not all low after reset");
        rst    = 1'b0;
        waited = 0;
        #1;
        while (!s_hdr_ready) begin
            waited++;
            if (waited > wait_limit) report_timeout("s_hdr_ready rising after reset");
            @(negedge clk);
            #1;
        end
        for (int i = 0; i < n_frames; i++) begin
            send_frame(i, (i > 0) ? frames[i - 1].stall : 1'b0);
        end
        @(posedge clk);
        hold_hdr = 1'b0;
        throttle = 1'b0;
        waited   = 0;
        while (exp_hdr_q.size() != 0 || exp_beat_q.size() != 0) begin
            waited++;
            if (waited > wait_limit) report_timeout("output of all headers and payload beats");
            @(posedge clk);
        end
        if (full_seen && stall_low > 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            stop_run("full header FIFO or payload back-pressure was never reached");
        end
    end

endmodule

// ==== hw/udp_csum_gen.sv ====
// udp checksum generator top with sequencer, length counter, accumulator and both FIFOs
`timescale 1ns/100ps

module udp_csum_gen import udp_csum_pkg::*; #(
    parameter int PAYLOAD_DEPTH = 64,
    parameter int HDR_DEPTH     = 4
) (
    input  logic              clk,
    input  logic              rst,
    // header in
    input  logic              s_hdr_valid,
    output logic              s_hdr_ready,
    input  logic [ip_w-1:0]   s_src_ip,
    input  logic [ip_w-1:0]   s_dst_ip,
    input  logic [port_w-1:0] s_src_port,
    input  logic [port_w-1:0] s_dst_port,
    // payload in
    input  logic [data_w-1:0] s_tdata,
    input  logic [keep_w-1:0] s_tkeep,
    input  logic              s_tvalid,
    output logic              s_tready,
    input  logic              s_tlast,
    // header out
    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output logic [ip_w-1:0]   m_src_ip,
    output logic [ip_w-1:0]   m_dst_ip,
    output logic [port_w-1:0] m_src_port,
    output logic [port_w-1:0] m_dst_port,
    output logic [len_w-1:0]  m_udp_length,
    output logic [csum_w-1:0] m_udp_checksum,
    // payload out
    output logic [data_w-1:0] m_tdata,
    output logic [keep_w-1:0] m_tkeep,
    output logic              m_tvalid,
    input  logic              m_tready,
    output logic              m_tlast,
    output logic              busy
);

    csum_op_t          csum_op;
    logic              payload_en;
    logic              len_start;
    logic              beat_acc;
    logic              hdr_push;
    logic              hdr_room;
    logic              fifo_room;
    logic              tvalid_room;
    logic              fifo_wr;
    logic [len_w-1:0]  udp_length;
    logic [ip_w-1:0]   hdr_src_ip;
    logic [ip_w-1:0]   hdr_dst_ip;
    logic [port_w-1:0] hdr_src_port;
    logic [port_w-1:0] hdr_dst_port;
    logic [csum_w-1:0] csum;

    // payload only moves while summing and while the FIFO has room
    assign tvalid_room = s_tvalid && fifo_room;
    assign s_tready    = payload_en && fifo_room;
    assign fifo_wr     = payload_en && tvalid_room;

    udp_csum_fsm fsm0 (
        .clk(clk), .rst(rst), .s_hdr_valid(s_hdr_valid), .s_tvalid(tvalid_room),
        .s_tlast(s_tlast), .hdr_room(hdr_room), .s_hdr_ready(s_hdr_ready),
        .payload_en(payload_en), .len_start(len_start), .beat_acc(beat_acc),
        .hdr_push(hdr_push), .busy(busy), .csum_op(csum_op)
    );

    udp_len_counter len0 (
        .clk(clk), .len_start(len_start), .beat_acc(beat_acc), .s_tkeep(s_tkeep),
        .udp_length(udp_length)
    );

    udp_csum_accum acc0 (
        .clk(clk), .csum_op(csum_op), .s_src_ip(s_src_ip), .s_dst_ip(s_dst_ip),
        .s_src_port(s_src_port), .s_dst_port(s_dst_port), .s_tdata(s_tdata),
        .s_tkeep(s_tkeep), .udp_length(udp_length), .hdr_src_ip(hdr_src_ip),
        .hdr_dst_ip(hdr_dst_ip), .hdr_src_port(hdr_src_port),
        .hdr_dst_port(hdr_dst_port), .csum(csum)
    );

    hdr_fifo #(.HDR_DEPTH(HDR_DEPTH)) hfifo0 (
        .clk(clk), .rst(rst), .hdr_push(hdr_push), .hdr_src_ip(hdr_src_ip),
        .hdr_dst_ip(hdr_dst_ip), .hdr_src_port(hdr_src_port), .hdr_dst_port(hdr_dst_port),
        .udp_length(udp_length), .csum(csum), .hdr_room(hdr_room),
        .m_hdr_valid(m_hdr_valid), .m_hdr_ready(m_hdr_ready), .m_src_ip(m_src_ip),
        .m_dst_ip(m_dst_ip), .m_src_port(m_src_port), .m_dst_port(m_dst_port),
        .m_udp_length(m_udp_length), .m_udp_checksum(m_udp_checksum)
    );

    payload_fifo #(.PAYLOAD_DEPTH(PAYLOAD_DEPTH)) pfifo0 (
        .clk(clk), .rst(rst), .wr_en(fifo_wr), .wr_data(s_tdata), .wr_keep(s_tkeep),
        .wr_last(s_tlast), .wr_room(fifo_room), .m_tdata(m_tdata), .m_tkeep(m_tkeep),
        .m_tlast(m_tlast), .m_tvalid(m_tvalid), .m_tready(m_tready)
    );

endmodule

// ==== hw/payload_fifo.sv ====
// payload FIFO for data, keep and last with a registered read stage
`timescale 1ns/100ps

module payload_fifo import udp_csum_pkg::*; #(
    parameter int PAYLOAD_DEPTH = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              wr_en,
    input  logic [data_w-1:0] wr_data,
    input  logic [keep_w-1:0] wr_keep,
    input  logic              wr_last,
    output logic              wr_room,
    output logic [data_w-1:0] m_tdata,
    output logic [keep_w-1:0] m_tkeep,
    output logic              m_tlast,
    output logic              m_tvalid,
    input  logic              m_tready
);

    localparam int addr_w = $clog2(PAYLOAD_DEPTH);
    localparam int word_w = data_w + keep_w + 1;

    logic [word_w-1:0] mem [PAYLOAD_DEPTH];
    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   rd_ptr;
    logic              full;
    logic              empty;
    logic              rd_en;

    assign full    = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                     (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    assign empty   = (wr_ptr == rd_ptr);
    assign wr_room = !full;
    assign rd_en   = !empty && (m_tready || !m_tvalid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            m_tvalid <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (m_tready || !m_tvalid) begin
                m_tvalid <= !empty;
            end
        end
        if (wr_en) begin
            mem[wr_ptr[addr_w-1:0]] <= {wr_last, wr_keep, wr_data};
        end
        if (rd_en) begin
            {m_tlast, m_tkeep, m_tdata} <= mem[rd_ptr[addr_w-1:0]];
        end
    end

    a_no_write_full: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);

endmodule

// ==== hw/hdr_fifo.sv ====
// header FIFO for finished udp headers with a registered output stage
`timescale 1ns/100ps

module hdr_fifo import udp_csum_pkg::*; #(
    parameter int HDR_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              hdr_push,
    input  logic [ip_w-1:0]   hdr_src_ip,
    input  logic [ip_w-1:0]   hdr_dst_ip,
    input  logic [port_w-1:0] hdr_src_port,
    input  logic [port_w-1:0] hdr_dst_port,
    input  logic [len_w-1:0]  udp_length,
    input  logic [csum_w-1:0] csum,
    output logic              hdr_room,
    output logic              m_hdr_valid,
    input  logic              m_hdr_ready,
    output logic [ip_w-1:0]   m_src_ip,
    output logic [ip_w-1:0]   m_dst_ip,
    output logic [port_w-1:0] m_src_port,
    output logic [port_w-1:0] m_dst_port,
    output logic [len_w-1:0]  m_udp_length,
    output logic [csum_w-1:0] m_udp_checksum
);

    localparam int addr_w = $clog2(HDR_DEPTH);
    localparam int word_w = 2 * ip_w + 2 * port_w + len_w + csum_w;

    logic [word_w-1:0] mem [HDR_DEPTH];
    logic [addr_w:0]   wr_ptr;
    logic [addr_w:0]   rd_ptr;
    logic              full;
    logic              empty;
    logic              rd_en;

    // wrap bits differ with equal index when full
    assign full     = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                      (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
    assign empty    = (wr_ptr == rd_ptr);
    assign hdr_room = !full;
    // reload output stage when it is empty or being taken
    assign rd_en    = !empty && (m_hdr_ready || !m_hdr_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            m_hdr_valid <= 1'b0;
        end else begin
            if (hdr_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (m_hdr_ready || !m_hdr_valid) begin
                m_hdr_valid <= !empty;
            end
        end
        if (hdr_push) begin
            mem[wr_ptr[addr_w-1:0]] <= {hdr_src_ip, hdr_dst_ip, hdr_src_port, hdr_dst_port,
                                        udp_length, csum};
        end
        if (rd_en) begin
            {m_src_ip, m_dst_ip, m_src_port, m_dst_port, m_udp_length, m_udp_checksum} <=
                mem[rd_ptr[addr_w-1:0]];
        end
    end

    a_no_push_full: assert property (@(posedge clk) disable iff (rst) hdr_push |-> !full);

endmodule

// ==== hw/udp_csum_accum.sv ====
// header capture registers and one's-complement checksum accumulator
`timescale 1ns/100ps

module udp_csum_accum import udp_csum_pkg::*; (
    input  logic              clk,
    input  csum_op_t          csum_op,
    input  logic [ip_w-1:0]   s_src_ip,
    input  logic [ip_w-1:0]   s_dst_ip,
    input  logic [port_w-1:0] s_src_port,
    input  logic [port_w-1:0] s_dst_port,
    input  logic [data_w-1:0] s_tdata,
    input  logic [keep_w-1:0] s_tkeep,
    input  logic [len_w-1:0]  udp_length,
    output logic [ip_w-1:0]   hdr_src_ip,
    output logic [ip_w-1:0]   hdr_dst_ip,
    output logic [port_w-1:0] hdr_src_port,
    output logic [port_w-1:0] hdr_dst_port,
    output logic [csum_w-1:0] csum
);

    logic [acc_w-1:0]  sum;
    logic [csum_w:0]   part_lo;
    logic [csum_w:0]   part_hi;
    logic [csum_w:0]   beat_lo;
    logic [csum_w:0]   beat_hi;
    logic [csum_w:0]   fold1;
    logic [csum_w-1:0] fold2;

    // even byte lanes go to the high half of each 16-bit word
    always_comb begin
        logic [7:0]        lane;
        logic [csum_w-1:0] word;
        beat_lo = '0;
        beat_hi = '0;
        for (int i = 0; i < keep_w; i++) begin
            lane = s_tkeep[i] ? s_tdata[i*8 +: 8] : 8'h00;
            word = i[0] ? {8'h00, lane} : {lane, 8'h00};
            if (i < keep_w / 2) begin
                beat_lo = beat_lo + word;
            end else begin
                beat_hi = beat_hi + word;
            end
        end
    end

    // two folds cover the worst case carry
    assign fold1 = {1'b0, sum[csum_w-1:0]} + sum[acc_w-1:csum_w];
    assign fold2 = fold1[csum_w-1:0] + csum_w'(fold1[csum_w]);

    always_ff @(posedge clk) begin
        case (csum_op)
            OP_LOAD: begin
                hdr_src_ip   <= s_src_ip;
                hdr_dst_ip   <= s_dst_ip;
                hdr_src_port <= s_src_port;
                hdr_dst_port <= s_dst_port;
                sum          <= acc_w'(udp_proto) + acc_w'(s_src_ip[31:16]) +
                                acc_w'(s_src_ip[15:0]);
                part_lo      <= '0;
                part_hi      <= '0;
            end
            OP_HDR: begin
                sum <= sum + acc_w'(hdr_dst_ip[31:16]) + acc_w'(hdr_dst_ip[15:0]) +
                       acc_w'(hdr_src_port) + acc_w'(hdr_dst_port);
            end
            OP_PAYLOAD: begin
                // previous beat's partials land now, this beat's wait a cycle
                sum     <= sum + acc_w'(part_lo) + acc_w'(part_hi);
                part_lo <= beat_lo;
                part_hi <= beat_hi;
            end
            OP_FLUSH: begin
                // pseudo-header and udp header both carry the length
                sum     <= sum + acc_w'(part_lo) + acc_w'(part_hi) +
                           acc_w'({udp_length, 1'b0});
                part_lo <= '0;
                part_hi <= '0;
            end
            OP_FOLD: begin
                sum <= acc_w'(~fold2);
            end
            default: begin
            end
        endcase
    end

    assign csum = sum[csum_w-1:0];

endmodule

// ==== hw/udp_len_counter.sv ====
// udp length counter fed by the keep bits of accepted payload beats
`timescale 1ns/100ps

module udp_len_counter import udp_csum_pkg::*; (
    input  logic              clk,
    input  logic              len_start,
    input  logic              beat_acc,
    input  logic [keep_w-1:0] s_tkeep,
    output logic [len_w-1:0]  udp_length
);

    // number of valid bytes in one beat
    function automatic logic [len_w-1:0] keep_bytes(input logic [keep_w-1:0] keep);
        logic [len_w-1:0] n;
        n = '0;
        for (int i = 0; i < keep_w; i++) begin
            n = n + len_w'(keep[i]);
        end
        return n;
    endfunction

    always_ff @(posedge clk) begin
        if (len_start) begin
            // udp header is counted up front
            udp_length <= udp_hdr_bytes;
        end else if (beat_acc) begin
            udp_length <= udp_length + keep_bytes(s_tkeep);
        end
    end

    // keep must be a run of ones starting at bit 0 on every accepted beat
    a_keep_contig: assert property (@(posedge clk)
        beat_acc |-> (s_tkeep != '0) &&
                     ((s_tkeep & (s_tkeep + keep_w'(1))) == '0));

endmodule

// ==== hw/udp_csum_fsm.sv ====
// frame sequencer FSM driving header capture, checksum opcodes, length counting and header commit
`timescale 1ns/100ps

module udp_csum_fsm import udp_csum_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     s_hdr_valid,
    input  logic     s_tvalid,
    input  logic     s_tlast,
    input  logic     hdr_room,
    output logic     s_hdr_ready,
    output logic     payload_en,
    output logic     len_start,
    output logic     beat_acc,
    output logic     hdr_push,
    output logic     busy,
    output csum_op_t csum_op
);

    csum_state_t state;
    csum_state_t state_next;
    logic        hdr_accept;

    assign hdr_accept = s_hdr_ready && s_hdr_valid;
    assign payload_en = (state == ST_SUM_PAYLOAD);
    // s_tvalid arrives already qualified with payload FIFO room
    assign beat_acc   = payload_en && s_tvalid;
    assign len_start  = hdr_accept;
    assign hdr_push   = (state == ST_COMMIT);

    always_comb begin
        state_next = state;
        csum_op    = OP_HOLD;
        case (state)
            ST_IDLE: begin
                if (hdr_accept) begin
                    csum_op    = OP_LOAD;
                    state_next = ST_SUM_HDR;
                end
            end
            ST_SUM_HDR: begin
                csum_op    = OP_HDR;
                state_next = ST_SUM_PAYLOAD;
            end
            ST_SUM_PAYLOAD: begin
                if (beat_acc) begin
                    csum_op = OP_PAYLOAD;
                    if (s_tlast) begin
                        state_next = ST_FLUSH;
                    end
                end
            end
            ST_FLUSH: begin
                csum_op    = OP_FLUSH;
                state_next = ST_FOLD;
            end
            ST_FOLD: begin
                csum_op    = OP_FOLD;
                state_next = ST_COMMIT;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_IDLE;
            s_hdr_ready <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            // drops right after an accept, returns once idle with room
            s_hdr_ready <= (state == ST_IDLE) && !hdr_accept && hdr_room;
            busy        <= (state_next != ST_IDLE);
        end
    end

    // a commit must always find a free slot in the header FIFO
    a_push_room: assert property (@(posedge clk) disable iff (rst) hdr_push |-> hdr_room);

endmodule

// ==== hw/udp_csum_pkg.sv ====
// udp checksum generator widths, protocol constants, sequencer states and accumulator opcodes
package udp_csum_pkg;

    // datapath widths
    localparam int data_w = 64;
    localparam int keep_w = 8;
    localparam int ip_w   = 32;
    localparam int port_w = 16;
    localparam int len_w  = 16;
    localparam int csum_w = 16;
    localparam int acc_w  = 32;

    // protocol constants
    localparam logic [7:0]       udp_proto     = 8'h11;
    localparam logic [len_w-1:0] udp_hdr_bytes = 16'd8;

    typedef enum logic [2:0] {
        ST_IDLE        = 3'd0,
        ST_SUM_HDR     = 3'd1,
        ST_SUM_PAYLOAD = 3'd2,
        ST_FLUSH       = 3'd3,
        ST_FOLD        = 3'd4,
        ST_COMMIT      = 3'd5
    } csum_state_t;

    typedef enum logic [2:0] {
        OP_HOLD    = 3'd0,
        OP_LOAD    = 3'd1,
        OP_HDR     = 3'd2,
        OP_PAYLOAD = 3'd3,
        OP_FLUSH   = 3'd4,
        OP_FOLD    = 3'd5
    } csum_op_t;

endpackage
